// ==== flist.f ====
+incdir+logic
logic/wb_bus_pkg.sv
logic/mem_word_pkg.sv
logic/wb_bus_if.sv
logic/wb_ram_slave.sv
logic/wb_host_master.sv
logic/wb_addr_decoder.sv
logic/wb_mem_top.sv
testbench/tb_wb_mem_top.sv

// ==== logic/mem_word_pkg.sv ====
// memory word types
// one bus word seen either whole or as separate byte lanes
`include "wb_cfg.svh"

package mem_word_pkg;

    // same bits two ways
    typedef union packed {
        logic [`WB_DW-1:0]        word;    // full word for reads
        logic [`WB_SELW-1:0][7:0] bytes;   // lane view for masked writes
    } bus_word_u;

endpackage

// ==== logic/wb_addr_decoder.sv ====
// wishbone address decoder
// region 0 and 1 go to the two rams, regions 2 and 3 answer with err
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_addr_decoder (
    input  logic     clk,
    input  logic     reset,
    wb_bus_if.slave  m_i,
    wb_bus_if.master s0_o,
    wb_bus_if.master s1_o
);

    localparam int RW = `WB_AW - `WB_RAM_AW;     // region bits

    logic [RW-1:0] region;
    logic          hit0;
    logic          hit1;
    logic          unmapped;
    logic          access;
    logic          rsel_q;                       // slave owning pending read data
    logic          err_q;

    assign region   = m_i.adr[`WB_AW-1 -: RW];
    assign hit0     = (region == 2'd0);
    assign hit1     = (region == 2'd1);
    assign unmapped = ~(hit0 | hit1);
    assign access   = m_i.cyc & m_i.stb;

    // request side, shared except for cyc/stb
    assign s0_o.adr   = m_i.adr[`WB_RAM_AW-1:0];
    assign s0_o.dat_w = m_i.dat_w;
    assign s0_o.sel   = m_i.sel;
    assign s0_o.cti   = m_i.cti;
    assign s0_o.we    = m_i.we;
    assign s0_o.cyc   = m_i.cyc & hit0;
    assign s0_o.stb   = access & hit0;           // only the addressed ram sees stb

    assign s1_o.adr   = m_i.adr[`WB_RAM_AW-1:0];
    assign s1_o.dat_w = m_i.dat_w;
    assign s1_o.sel   = m_i.sel;
    assign s1_o.cti   = m_i.cti;
    assign s1_o.we    = m_i.we;
    assign s1_o.cyc   = m_i.cyc & hit1;
    assign s1_o.stb   = access & hit1;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsel_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            if (access && !unmapped) begin
                rsel_q <= hit1;                  // data returns a cycle later
            end
            err_q <= access & unmapped & ~err_q; // one err per request
        end
    end

    // response side
    assign m_i.ack   = (hit0 & s0_o.ack) | (hit1 & s1_o.ack);
    assign m_i.dat_r = rsel_q ? s1_o.dat_r : s0_o.dat_r;
    assign m_i.err   = err_q | (hit0 & s0_o.err) | (hit1 & s1_o.err);
    assign m_i.rty   = (hit0 & s0_o.rty) | (hit1 & s1_o.rty);

endmodule

// ==== logic/wb_bus_if.sv ====
// wishbone bus segment
// one master side and one slave side, address width set per segment
`timescale 1ns/100ps
`include "wb_cfg.svh"

interface wb_bus_if import wb_bus_pkg::*; #(
    parameter int AW = `WB_AW           // word address bits on this segment
) ();

    // master to slave
    logic [AW-1:0]       adr;
    logic [`WB_DW-1:0]   dat_w;
    logic [`WB_SELW-1:0] sel;
    wb_cti_e             cti;
    logic                cyc;
    logic                stb;           // only meaningful with cyc
    logic                we;

    // slave to master
    logic [`WB_DW-1:0]   dat_r;         // one cycle behind the address
    logic                ack;
    logic                err;
    logic                rty;

    modport master (
        output adr, dat_w, sel, cti, cyc, stb, we,
        input  dat_r, ack, err, rty
    );

    modport slave (
        input  adr, dat_w, sel, cti, cyc, stb, we,
        output dat_r, ack, err, rty
    );

endinterface

// ==== logic/wb_bus_pkg.sv ====
// wishbone bus protocol types
// cycle tag encoding and burst length as seen on the host port
`include "wb_cfg.svh"

package wb_bus_pkg;

    // cycle type identifier values in use
    typedef enum logic [`WB_TAGW-1:0] {
        CTI_CLASSIC = 3'b000,   // single access with registered ack
        CTI_INCR    = 3'b010,   // incrementing burst beat
        CTI_EOB     = 3'b111    // last beat of a burst
    } wb_cti_e;

    // beats minus one
    typedef logic [$clog2(`WB_MAX_BURST)-1:0] burst_len_t;

endpackage

// ==== logic/wb_cfg.svh ====
// wishbone memory subsystem configuration
// bus widths, ram depth and burst limit shared by all blocks
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// data path
`define WB_DW        32
`define WB_SELW      (`WB_DW / 8)     // one select bit per byte lane

// addressing in words
`define WB_AW        12               // top two bits pick the region
`define WB_RAM_AW    10               // word address inside one ram

// cycle tag and burst
`define WB_TAGW      3
`define WB_MAX_BURST 4                // beats per burst read at most

`endif

// ==== logic/wb_host_master.sv ====
// host to wishbone master
// takes four-phase req/ack commands and runs classic cycles or
// incrementing burst reads and streams read beats back on rvalid_o
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_host_master import wb_bus_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    // host command port
    input  logic                req_i,
    input  logic                we_i,
    input  logic [`WB_AW-1:0]   addr_i,
    input  logic [`WB_SELW-1:0] sel_i,
    input  logic [`WB_DW-1:0]   wdata_i,
    input  burst_len_t          len_i,
    output logic                ack_o,
    output logic                err_o,
    output logic [`WB_DW-1:0]   rdata_o,
    output logic                rvalid_o,
    // wishbone side
    wb_bus_if.master            bus_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLASSIC,                      // one beat waiting for the registered ack
        ST_BURST,                        // pipelined beats
        ST_DRAIN,                        // last burst data still in flight
        ST_DONE                          // ack_o high until req_i drops
    } state_e;

    state_e              state_q;
    logic                cyc_q;
    logic                stb_q;
    logic                rd_pend_q;      // read beat accepted last cycle
    burst_len_t          beat_q;         // beats issued so far
    burst_len_t          beat_nxt;

    // latched command
    logic                we_q;
    logic [`WB_AW-1:0]   adr_q;
    logic [`WB_SELW-1:0] sel_q;
    logic [`WB_DW-1:0]   dat_q;
    burst_len_t          len_q;
    wb_cti_e             cti_q;

    logic start;
    logic beat_ok;
    logic beat_fail;
    logic advance;                       // burst moves to next address

    assign start     = (state_q == ST_IDLE) & req_i;
    assign beat_ok   = stb_q & bus_o.ack;
    assign beat_fail = stb_q & (bus_o.err | bus_o.rty);  // retry treated as failure
    assign beat_nxt  = beat_q + 1'b1;
    assign advance   = (state_q == ST_BURST) & beat_ok & ~beat_fail & (beat_q != len_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            cyc_q     <= 1'b0;
            stb_q     <= 1'b0;
            ack_o     <= 1'b0;
            err_o     <= 1'b0;
            rd_pend_q <= 1'b0;
            beat_q    <= '0;
        end else begin
            rd_pend_q <= 1'b0;                       // pulse per accepted beat
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        cyc_q  <= 1'b1;
                        stb_q  <= 1'b1;
                        beat_q <= '0;
                        // writes and single reads are classic
                        state_q <= (we_i || len_i == '0) ? ST_CLASSIC : ST_BURST;
                    end
                end
                ST_CLASSIC: begin
                    if (beat_ok || beat_fail) begin
                        cyc_q   <= 1'b0;
                        stb_q   <= 1'b0;
                        ack_o   <= 1'b1;
                        err_o   <= beat_fail;
                        state_q <= ST_DONE;
                    end
                end
                ST_BURST: begin
                    if (beat_fail) begin             // abort at the failing beat
                        cyc_q   <= 1'b0;
                        stb_q   <= 1'b0;
                        ack_o   <= 1'b1;
                        err_o   <= 1'b1;
                        state_q <= ST_DONE;
                    end else if (beat_ok) begin
                        rd_pend_q <= 1'b1;           // data shows next cycle
                        if (beat_q == len_q) begin
                            cyc_q   <= 1'b0;
                            stb_q   <= 1'b0;
                            state_q <= ST_DRAIN;
                        end else begin
                            beat_q <= beat_nxt;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (rd_pend_q) begin             // last beat returned
                        ack_o   <= 1'b1;
                        err_o   <= 1'b0;
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!req_i) begin                // phase 4 of handshake
                        ack_o   <= 1'b0;
                        err_o   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command payload and running burst address
    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= we_i;
            adr_q <= addr_i;
            sel_q <= sel_i;
            dat_q <= wdata_i;
            len_q <= len_i;
            cti_q <= (we_i || len_i == '0) ? CTI_CLASSIC : CTI_INCR;
        end else if (advance) begin
            adr_q <= adr_q + 1'b1;                   // wraps across regions freely
            cti_q <= (beat_nxt == len_q) ? CTI_EOB : CTI_INCR;
        end
    end

    assign bus_o.adr   = adr_q;
    assign bus_o.dat_w = dat_q;
    assign bus_o.sel   = sel_q;
    assign bus_o.cti   = cti_q;
    assign bus_o.cyc   = cyc_q;
    assign bus_o.stb   = stb_q;
    assign bus_o.we    = we_q;

    // classic read data comes with the ack, burst data a cycle after it
    assign rvalid_o = ((state_q == ST_CLASSIC) & ~we_q & beat_ok & ~beat_fail) | rd_pend_q;
    assign rdata_o  = bus_o.dat_r;

endmodule

// ==== logic/wb_mem_top.sv ====
// wishbone memory subsystem top
// host master, address decoder and two ram slaves on three bus segments
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_mem_top import wb_bus_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_i,
    input  logic                we_i,
    input  logic [`WB_AW-1:0]   addr_i,
    input  logic [`WB_SELW-1:0] sel_i,
    input  logic [`WB_DW-1:0]   wdata_i,
    input  burst_len_t          len_i,
    output logic                ack_o,
    output logic                err_o,
    output logic [`WB_DW-1:0]   rdata_o,
    output logic                rvalid_o
);

    wb_bus_if #(.AW(`WB_AW))     m_bus  ();   // master to decoder
    wb_bus_if #(.AW(`WB_RAM_AW)) s0_bus ();   // region 0
    wb_bus_if #(.AW(`WB_RAM_AW)) s1_bus ();   // region 1

    wb_host_master i_wb_host_master (
        .clk      (clk),
        .reset    (reset),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .sel_i    (sel_i),
        .wdata_i  (wdata_i),
        .len_i    (len_i),
        .ack_o    (ack_o),
        .err_o    (err_o),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o),
        .bus_o    (m_bus.master)
    );

    wb_addr_decoder i_wb_addr_decoder (
        .clk   (clk),
        .reset (reset),
        .m_i   (m_bus.slave),
        .s0_o  (s0_bus.master),
        .s1_o  (s1_bus.master)
    );

    wb_ram_slave i_wb_ram_slave_0 (
        .clk   (clk),
        .reset (reset),
        .bus_i (s0_bus.slave)
    );

    wb_ram_slave i_wb_ram_slave_1 (
        .clk   (clk),
        .reset (reset),
        .bus_i (s1_bus.slave)
    );

endmodule

// ==== logic/wb_ram_slave.sv ====
// wishbone ram slave
// single port ram with byte lane writes and registered read data
// classic cycles get a registered ack, burst beats an immediate one
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_ram_slave import wb_bus_pkg::*, mem_word_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    wb_bus_if.slave bus_i
);

    localparam int DEPTH = 1 << `WB_RAM_AW;

    bus_word_u mem [0:DEPTH-1];          // behavioural storage

    bus_word_u            wr_word;       // write data in lane view
    bus_word_u            rd_q;          // registered read word
    logic                 access;        // valid strobe
    logic                 wr_en;
    logic                 ack_classic_q;
    logic                 ack_burst;
    logic [`WB_RAM_AW-1:0] word_adr;

    assign access   = bus_i.cyc & bus_i.stb;
    assign wr_en    = access & bus_i.we;
    assign word_adr = bus_i.adr;
    assign wr_word.word = bus_i.dat_w;

    // write lanes on sel, read every cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `WB_SELW; i++) begin
                if (bus_i.sel[i]) begin
                    mem[word_adr].bytes[i] <= wr_word.bytes[i];  // masked lane
                end
            end
        end
        rd_q <= mem[word_adr];           // old word on a write
    end

    assign bus_i.dat_r = rd_q.word;

    // classic ack one cycle after strobe, dropped once given
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_classic_q <= 1'b0;
        end else begin
            ack_classic_q <= access & ~bus_i.ack;
        end
    end

    // burst beats ack right away, master takes data a cycle later
    assign ack_burst = access;

    assign bus_i.ack = (bus_i.cti == CTI_CLASSIC) ? ack_classic_q : ack_burst;

    // ram never fails or asks for retry
    assign bus_i.err = 1'b0;
    assign bus_i.rty = 1'b0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the wishbone memory testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_mem_top \
    -f flist.f -o tb_wb_mem_top || exit 1

out=$(./obj_dir/tb_wb_mem_top 2>&1)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_wb_mem_top.sv ====
// testbench for the wishbone memory subsystem
// drives four-phase host commands, keeps a shadow of both rams
// and checks read data, err_o and ack_o timing
`timescale 1ns/100ps
`include "wb_cfg.svh"

module tb_wb_mem_top import wb_bus_pkg::*;;

    localparam int CLK_PERIOD = 8;
    localparam int RAM_IDX_W  = `WB_RAM_AW + 1;       // both rams in one shadow
    localparam int ACK_WAIT   = 4 * `WB_MAX_BURST + 8;
    localparam int DROP_WAIT  = 4;

    logic                clk;
    logic                reset;
    logic                req_i;
    logic                we_i;
    logic [`WB_AW-1:0]   addr_i;
    logic [`WB_SELW-1:0] sel_i;
    logic [`WB_DW-1:0]   wdata_i;
    burst_len_t          len_i;
    logic                ack_o;
    logic                err_o;
    logic [`WB_DW-1:0]   rdata_o;
    logic                rvalid_o;

    // shadow of ram 0 and ram 1 with lanes never written left unknown
    logic [`WB_DW-1:0]   shadow [0:(1<<RAM_IDX_W)-1];
    logic [`WB_SELW-1:0] known  [0:(1<<RAM_IDX_W)-1];

    logic [`WB_DW-1:0]   exp_data_q [$];              // one entry per read beat
    logic [`WB_DW-1:0]   exp_mask_q [$];
    logic                exp_err;
    logic [`WB_DW-1:0]   exp_d;
    logic [`WB_DW-1:0]   exp_m;
    logic                ack_seen;

    logic [`WB_AW-1:0]   wr_adr_q [$];                // words written in phase 1
    logic [31:0]         rnd;
    logic [`WB_AW-1:0]   adr_v;
    logic [`WB_SELW-1:0] sel_v;
    integer              seed = 15328;
    int                  j;

    wb_mem_top i_wb_mem_top (
        .clk      (clk),
        .reset    (reset),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .sel_i    (sel_i),
        .wdata_i  (wdata_i),
        .len_i    (len_i),
        .ack_o    (ack_o),
        .err_o    (err_o),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // byte lanes to a bit mask
    function automatic logic [`WB_DW-1:0] lane_bits(input logic [`WB_SELW-1:0] lanes);
        logic [`WB_DW-1:0] m;
        int i;
        for (i = 0; i < `WB_SELW; i++) begin
            m[8*i +: 8] = {8{lanes[i]}};
        end
        return m;
    endfunction

    // expected word and known lanes plus the unmapped flag
    function automatic logic ref_read(input logic [`WB_AW-1:0] adr,
                                      output logic [`WB_DW-1:0] data,
                                      output logic [`WB_SELW-1:0] lanes);
        data  = shadow[adr[RAM_IDX_W-1:0]];
        lanes = known[adr[RAM_IDX_W-1:0]];
        return (adr[`WB_AW-1 -: 2] > 2'd1);           // regions 2 and 3
    endfunction

    task automatic shadow_write(input logic [`WB_AW-1:0] adr,
                                input logic [`WB_SELW-1:0] sel,
                                input logic [`WB_DW-1:0] data);
        int i;
        for (i = 0; i < `WB_SELW; i++) begin
            if (sel[i]) begin
                shadow[adr[RAM_IDX_W-1:0]][8*i +: 8] = data[8*i +: 8];
                known[adr[RAM_IDX_W-1:0]][i] = 1'b1;
            end
        end
    endtask

    // one full four-phase command with req_i held for hold cycles after ack_o
    task automatic run_cmd(input logic we, input logic [`WB_AW-1:0] adr,
                           input logic [`WB_SELW-1:0] sel, input logic [`WB_DW-1:0] wdata,
                           input burst_len_t len, input int hold);
        int beats;
        int err_beat;
        int exp_lat;
        int n;
        int i;
        logic [`WB_AW-1:0]   a;
        logic [`WB_DW-1:0]   d;
        logic [`WB_SELW-1:0] k;
        beats    = we ? 1 : int'(len) + 1;
        err_beat = -1;
        for (i = 0; i < beats && err_beat < 0; i++) begin
            a = adr + i[`WB_AW-1:0];                   // wraps like the bus address
            if (ref_read(a, d, k)) begin
                err_beat = i;                          // burst stops here
            end else if (!we) begin
                exp_data_q.push_back(d);
                exp_mask_q.push_back(lane_bits(k));
            end
        end
        exp_err = (err_beat >= 0);
        exp_lat = exp_err ? err_beat + 3 : beats + 2;
        if (we && !exp_err) begin
            shadow_write(adr, sel, wdata);
        end
        @(posedge clk);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= adr;
        sel_i   <= sel;
        wdata_i <= wdata;
        len_i   <= len;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack_o && n < ACK_WAIT);
        if (!ack_o) begin
            $display("no ack_o within %0d cycles for command at address %h", ACK_WAIT, adr);
            abort_run();
        end
        assert (n - 1 == exp_lat) else begin          // first negedge is before cycle 0
            $display("FAIL t=%0t ack_o latency got %0d expected %0d", $time, n - 1, exp_lat);
            abort_run();
        end
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            assert (ack_o) else begin
                $display("FAIL t=%0t ack_o got %b expected 1", $time, ack_o);
                abort_run();
            end
        end
        @(posedge clk);
        req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ack_o && n < DROP_WAIT);
        if (ack_o) begin
            $display("ack_o still high %0d cycles after req_i was dropped", DROP_WAIT);
            abort_run();
        end
    endtask

    // compare every read beat and the err flag on each rising ack_o
    always @(negedge clk) begin
        if (!reset) begin
            if (rvalid_o) begin
                if (exp_data_q.size() == 0) begin
                    $display("read beat on rvalid_o at %0t with none expected", $time);
                    abort_run();
                end
                exp_d = exp_data_q.pop_front();
                exp_m = exp_mask_q.pop_front();
                assert ((rdata_o & exp_m) === (exp_d & exp_m)) else begin
                    $display("FAIL t=%0t rdata_o got %h expected %h (mask %h)",
                             $time, rdata_o, exp_d, exp_m);
                    abort_run();
                end
            end
            if (ack_o && !ack_seen) begin
                assert (err_o === exp_err) else begin
                    $display("FAIL t=%0t err_o got %b expected %b", $time, err_o, exp_err);
                    abort_run();
                end
                if (exp_data_q.size() != 0) begin
                    $display("ack_o at %0t with %0d read beats missing", $time,
                             exp_data_q.size());
                    abort_run();
                end
            end
            ack_seen = ack_o;
        end
    end

    initial begin
        reset    = 1'b1;
        req_i    = 1'b0;
        we_i     = 1'b0;
        addr_i   = '0;
        sel_i    = '0;
        wdata_i  = '0;
        len_i    = '0;
        exp_err  = 1'b0;
        ack_seen = 1'b0;
        for (j = 0; j < (1 << RAM_IDX_W); j++) begin
            known[j] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // full words in both rams read back at once
        for (j = 0; j < 12; j++) begin
            rnd   = $random(seed);
            adr_v = {1'b0, rnd[10:0]};                 // region 0 or 1
            wr_adr_q.push_back(adr_v);
            run_cmd(1'b1, adr_v, 4'hF, $random(seed), '0, 0);
            run_cmd(1'b0, adr_v, 4'hF, '0, '0, 0);
        end
        // burst windows across the ram boundary and below region 2
        for (j = 0; j < 16; j++) begin
            run_cmd(1'b1, 12'h3F8 + j[11:0], 4'hF, $random(seed), '0, 0);
        end
        for (j = 0; j < 4; j++) begin
            run_cmd(1'b1, 12'h7FC + j[11:0], 4'hF, $random(seed), '0, 0);
        end

        // partial lane writes merge into the old word
        for (j = 0; j < 8; j++) begin
            rnd   = $random(seed);
            adr_v = wr_adr_q[rnd[3:0] % wr_adr_q.size()];
            sel_v = rnd[7:4];
            if (sel_v == 4'h0 || sel_v == 4'hF) begin
                sel_v = 4'b0110;
            end
            run_cmd(1'b1, adr_v, sel_v, $random(seed), '0, 0);
            run_cmd(1'b0, adr_v, 4'hF, '0, '0, 0);
        end

        // bursts of 1 to 4 beats inside the window
        for (j = 0; j < 16; j++) begin
            rnd   = $random(seed);
            adr_v = 12'h3F8 + (rnd[3:0] % 13);
            run_cmd(1'b0, adr_v, 4'hF, '0, burst_len_t'(j % 4), 0);
        end
        run_cmd(1'b0, 12'h3FE, 4'hF, '0, 2'd3, 0);     // ram 0 into ram 1
        run_cmd(1'b0, 12'h7FE, 4'hF, '0, 2'd3, 0);     // runs into region 2
        run_cmd(1'b0, 12'hBFF, 4'hF, '0, 2'd2, 0);     // err on first beat

        // both ram aliases hold known words around the unmapped accesses
        for (j = 0; j < 6; j++) begin
            rnd   = $random(seed);
            adr_v = wr_adr_q[j];
            run_cmd(1'b1, {2'b00, adr_v[9:0]}, 4'hF, $random(seed), '0, 0);
            run_cmd(1'b1, {2'b01, adr_v[9:0]}, 4'hF, $random(seed), '0, 0);
            run_cmd(1'b1, {1'b1, rnd[0], adr_v[9:0]}, 4'hF, $random(seed), '0, 0);
            run_cmd(1'b0, {1'b1, ~rnd[0], adr_v[9:0]}, 4'hF, '0, burst_len_t'(rnd[2:1]), 0);
            run_cmd(1'b0, {2'b00, adr_v[9:0]}, 4'hF, '0, '0, 0);
            run_cmd(1'b0, {2'b01, adr_v[9:0]}, 4'hF, '0, '0, 0);
        end

        // host keeps req_i high after ack_o
        run_cmd(1'b1, wr_adr_q[0], 4'hF, $random(seed), '0, 4);
        run_cmd(1'b0, wr_adr_q[0], 4'hF, '0, '0, 3);
        run_cmd(1'b0, 12'h3FC, 4'hF, '0, 2'd3, 5);
        run_cmd(1'b0, 12'hC10, 4'hF, '0, '0, 2);

        repeat (2) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
